//--- compile.f
design/sadPkg.sv
design/blockPacker.sv
design/memSadLatch.sv
design/sadEngine.sv
design/sadTop.sv
dv/tbClock.sv
dv/sadTop_asserts.sv
dv/sadTb.sv

//--- design/blockPacker.sv
`timescale 1ns/1ps

module blockPacker import sadPkg::*; #(
        parameter int PixWidth  = 8,
        parameter int BlockSize = 16
) (
        input  logic                          Clk,
        input  logic                          arstN,
        input  logic                          pixValid,
        input  logic [PixWidth-1:0]           pixData,
        input  sadOpT                         op,
        input  logic [31:0]                   fad,
        input  logic                          blkReady,
        output logic                          pixReady,
        output logic                          blkValid,
        output sadOpT                         blkOp,
        output logic [31:0]                   blkFad,
        output logic [BlockSize*PixWidth-1:0] blkData
);

        localparam int BlkWidth = BlockSize * PixWidth;
        localparam int CntWidth = $clog2(BlockSize);

        packStateT            state;
        logic [CntWidth-1:0]  beatCnt;
        logic                 beat;
        logic                 lastBeat;

        ////////////////////////////////////////////////////////////////////////////
        // Handshake
        ////////////////////////////////////////////////////////////////////////////

        // No new pixels while a finished block waits for the latch
        assign pixReady = (state != Hold);
        assign blkValid = (state == Hold);

        assign beat     = pixValid && pixReady;
        assign lastBeat = (beatCnt == CntWidth'(BlockSize - 1));

        ////////////////////////////////////////////////////////////////////////////
        // Beat counter and state
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge Clk or negedge arstN) begin
                if (!arstN) begin
                        state   <= Idle;
                        beatCnt <= '0;
                end else begin
                        case (state)
                                Idle: begin
                                        if (beat) begin
                                                beatCnt <= CntWidth'(1);
                                                state   <= Fill;
                                        end
                                end
                                Fill: begin
                                        if (beat) begin
                                                if (lastBeat) begin
                                                        beatCnt <= '0;
                                                        state   <= Hold;
                                                end else begin
                                                        beatCnt <= beatCnt + CntWidth'(1);
                                                end
                                        end
                                end
                                Hold: begin
                                        if (blkReady) begin
                                                state <= Idle;
                                        end
                                end
                                default: begin
                                        state   <= Idle;
                                        beatCnt <= '0;
                                end
                        endcase
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Block payload
        ////////////////////////////////////////////////////////////////////////////

        // Pixels enter at the top and shift down, first pixel ends in slot 0
        always_ff @(posedge Clk) begin
                if (beat) begin
                        blkData <= {pixData, blkData[BlkWidth-1:PixWidth]};
                end
                // Opcode and address belong to the first beat only
                if (beat && state == Idle) begin
                        blkOp  <= op;
                        blkFad <= fad;
                end
        end

endmodule

//--- design/memSadLatch.sv
`timescale 1ns/1ps

module memSadLatch import sadPkg::*; #(
        parameter int PixWidth  = 8,
        parameter int BlockSize = 16
) (
        input  logic                          Clk,
        input  logic                          arstN,
        input  logic                          blkValid,
        input  sadOpT                         blkOp,
        input  logic [31:0]                   blkFad,
        input  logic [BlockSize*PixWidth-1:0] blkData,
        input  logic                          entReady,
        output logic                          blkReady,
        output logic                          entValid,
        output sadOpT                         entOp,
        output logic [31:0]                   entFad,
        output logic [BlockSize*PixWidth-1:0] winData,
        output logic [BlockSize*PixWidth-1:0] frmData
);

        logic accept;
        logic isWindow;
        logic isFrame;

        // Slot frees up in the same cycle its entry is taken
        assign blkReady = !entValid || entReady;
        assign accept   = blkValid && blkReady;

        assign isWindow = (blkOp == SadWindow);
        assign isFrame  = (blkOp == SadFrame) || (blkOp == SadFrameLast);

        ////////////////////////////////////////////////////////////////////////////
        // Frame slot occupancy
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge Clk or negedge arstN) begin
                if (!arstN) begin
                        entValid <= 1'b0;
                end else if (accept && isFrame) begin
                        entValid <= 1'b1;
                end else if (entReady) begin
                        entValid <= 1'b0;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Window and frame registers
        ////////////////////////////////////////////////////////////////////////////

        // Window and Nop blocks are absorbed here and never reach the engine
        always_ff @(posedge Clk) begin
                if (accept) begin
                        if (isWindow) begin
                                winData <= blkData;
                        end else if (isFrame) begin
                                frmData <= blkData;
                                entOp   <= blkOp;
                                entFad  <= blkFad;
                        end
                end
        end

endmodule

//--- design/sadEngine.sv
`timescale 1ns/1ps

module sadEngine import sadPkg::*; #(
        parameter int PixWidth  = 8,
        parameter int BlockSize = 16
) (
        input  logic                                   Clk,
        input  logic                                   arstN,
        input  logic                                   entValid,
        input  sadOpT                                  entOp,
        input  logic [31:0]                            entFad,
        input  logic [BlockSize*PixWidth-1:0]          winData,
        input  logic [BlockSize*PixWidth-1:0]          frmData,
        input  logic                                   resReady,
        output logic                                   entReady,
        output logic                                   resValid,
        output logic [PixWidth+$clog2(BlockSize)-1:0]  resSad,
        output logic [31:0]                            resFad
);

        // Wide enough for BlockSize maximal differences
        localparam int SadWidth = PixWidth + $clog2(BlockSize);

        engStateT                       state;
        logic                           advance;

        // Stage one
        logic                           s1Valid;
        sadOpT                          s1Op;
        logic [31:0]                    s1Fad;
        logic [BlockSize*PixWidth-1:0]  absDiff;

        // Stage two
        logic [SadWidth-1:0]            sadSum;
        logic                           better;
        logic [SadWidth-1:0]            newSad;
        logic [31:0]                    newFad;
        logic                           bestHit;
        logic [SadWidth-1:0]            bestSad;
        logic [31:0]                    bestFad;

        function automatic logic [PixWidth-1:0] pixAbsDiff(input logic [PixWidth-1:0] a,
                                                           input logic [PixWidth-1:0] b);
                return (a > b) ? (a - b) : (b - a);
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Pipeline control
        ////////////////////////////////////////////////////////////////////////////

        // Whole pipeline freezes while a result waits
        assign advance  = (state == Run) || resReady;
        assign entReady = advance;
        assign resValid = (state == Report);

        always_ff @(posedge Clk or negedge arstN) begin
                if (!arstN) begin
                        state   <= Run;
                        s1Valid <= 1'b0;
                        bestHit <= 1'b0;
                end else if (advance) begin
                        s1Valid <= entValid;
                        state   <= Run;
                        if (s1Valid) begin
                                if (s1Op == SadFrameLast) begin
                                        // Result moves to the output, next sequence starts fresh
                                        state   <= Report;
                                        bestHit <= 1'b0;
                                end else begin
                                        bestHit <= 1'b1;
                                end
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Stage one: per-pixel absolute differences
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (advance) begin
                        for (int i = 0; i < BlockSize; i++) begin
                                absDiff[i*PixWidth +: PixWidth] <=
                                        pixAbsDiff(winData[i*PixWidth +: PixWidth],
                                                   frmData[i*PixWidth +: PixWidth]);
                        end
                        s1Op  <= entOp;
                        s1Fad <= entFad;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Stage two: sum, compare, keep best
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                sadSum = '0;
                for (int i = 0; i < BlockSize; i++) begin
                        sadSum = sadSum + SadWidth'(absDiff[i*PixWidth +: PixWidth]);
                end
        end

        // Strictly smaller only, so the earlier frame keeps a tie
        assign better = !bestHit || (sadSum < bestSad);
        assign newSad = better ? sadSum : bestSad;
        assign newFad = better ? s1Fad : bestFad;

        always_ff @(posedge Clk) begin
                if (advance && s1Valid) begin
                        bestSad <= newSad;
                        bestFad <= newFad;
                        if (s1Op == SadFrameLast) begin
                                resSad <= newSad;
                                resFad <= newFad;
                        end
                end
        end

endmodule

//--- design/sadPkg.sv
package sadPkg;

        // Block opcode, same encoding as the memory-to-SAD latch of the core
        typedef enum logic [1:0] {
                SadNop       = 2'd0,
                SadFrame     = 2'd1,
                SadFrameLast = 2'd2,
                SadWindow    = 2'd3
        } sadOpT;

        // Packer: waiting for first beat, collecting beats, holding a full block
        typedef enum logic [1:0] {
                Idle = 2'd0,
                Fill = 2'd1,
                Hold = 2'd2
        } packStateT;

        // Engine output side
        typedef enum logic {
                Run    = 1'b0,
                Report = 1'b1
        } engStateT;

endpackage

//--- design/sadTop.sv
`timescale 1ns/1ps

module sadTop import sadPkg::*; #(
        parameter int PixWidth  = 8,
        parameter int BlockSize = 16
) (
        input  logic                                   Clk,
        input  logic                                   arstN,
        input  logic                                   pixValid,
        input  logic [PixWidth-1:0]                    pixData,
        input  sadOpT                                  op,
        input  logic [31:0]                            fad,
        input  logic                                   resReady,
        output logic                                   pixReady,
        output logic                                   resValid,
        output logic [PixWidth+$clog2(BlockSize)-1:0]  resSad,
        output logic [31:0]                            resFad
);

        localparam int BlkWidth = BlockSize * PixWidth;

        ////////////////////////////////////////////////////////////////////////////
        // Packer to latch
        ////////////////////////////////////////////////////////////////////////////

        logic                 blkValid;
        logic                 blkReady;
        sadOpT                blkOp;
        logic [31:0]          blkFad;
        logic [BlkWidth-1:0]  blkData;

        ////////////////////////////////////////////////////////////////////////////
        // Latch to engine
        ////////////////////////////////////////////////////////////////////////////

        logic                 entValid;
        logic                 entReady;
        sadOpT                entOp;
        logic [31:0]          entFad;
        logic [BlkWidth-1:0]  winData;
        logic [BlkWidth-1:0]  frmData;

        blockPacker #(
                .PixWidth  (PixWidth),
                .BlockSize (BlockSize)
        ) packer0 (
                .Clk      (Clk),
                .arstN    (arstN),
                .pixValid (pixValid),
                .pixData  (pixData),
                .op       (op),
                .fad      (fad),
                .blkReady (blkReady),
                .pixReady (pixReady),
                .blkValid (blkValid),
                .blkOp    (blkOp),
                .blkFad   (blkFad),
                .blkData  (blkData)
        );

        memSadLatch #(
                .PixWidth  (PixWidth),
                .BlockSize (BlockSize)
        ) latch0 (
                .Clk      (Clk),
                .arstN    (arstN),
                .blkValid (blkValid),
                .blkOp    (blkOp),
                .blkFad   (blkFad),
                .blkData  (blkData),
                .entReady (entReady),
                .blkReady (blkReady),
                .entValid (entValid),
                .entOp    (entOp),
                .entFad   (entFad),
                .winData  (winData),
                .frmData  (frmData)
        );

        sadEngine #(
                .PixWidth  (PixWidth),
                .BlockSize (BlockSize)
        ) engine0 (
                .Clk      (Clk),
                .arstN    (arstN),
                .entValid (entValid),
                .entOp    (entOp),
                .entFad   (entFad),
                .winData  (winData),
                .frmData  (frmData),
                .resReady (resReady),
                .entReady (entReady),
                .resValid (resValid),
                .resSad   (resSad),
                .resFad   (resFad)
        );

endmodule

//--- dv/sadInput.txt
# B op fad pix0 .. pix15   (op 0 Nop, 1 Frame, 2 FrameLast, 3 Window; all hex)
# R expectedSad expectedFad   (hex)
B 3 00000000 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0
B 2 00001000 05 0d 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 ff
R 017 00001000
B 1 00002000 04 14 24 34 44 54 64 74 84 94 a4 b4 c4 d4 e4 f4
B 1 00002100 02 12 22 32 42 52 62 72 82 92 a2 b2 c2 d2 e2 f2
B 0 00002200 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0
B 1 00002300 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 d0
B 2 00002400 03 13 23 33 43 53 63 73 83 93 a3 b3 c3 d3 e3 f3
R 020 00002100
B 3 00000000 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
B 0 00002f00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B 1 00003000 84 84 84 84 84 84 84 84 84 84 84 84 84 84 84 84
B 2 00003100 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a 7a
R 040 00003000
B 0 00003f00 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
B 2 00004000 80 81 82 83 84 85 86 87 7f 7e 7d 7c 7b 7a 79 78
R 040 00004000
B 3 00000000 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
B 1 00005000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B 2 00005100 fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe
R 010 00005100
B 1 00006000 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0 f0
B 1 00006100 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8
B 2 00006200 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8 f8
R 070 00006100

//--- dv/sadTb.sv
`timescale 1ns/1ps

module sadTb import sadPkg::*; ();

        localparam int PixWidth    = 8;
        localparam int BlockSize   = 16;
        localparam int SadWidth    = PixWidth + $clog2(BlockSize);
        localparam int BlkWidth    = PixWidth * BlockSize;
        localparam int WaitLimit   = 2000;
        localparam int QuietCycles = 30;

        logic                 Clk;
        logic                 arstN;
        logic                 pixValid;
        logic [PixWidth-1:0]  pixData;
        sadOpT                op;
        logic [31:0]          fad;
        logic                 resReady;
        logic                 pixReady;
        logic                 resValid;
        logic [SadWidth-1:0]  resSad;
        logic [31:0]          resFad;

        // Block commands and expected results, in file order
        sadOpT                blkOpQ[$];
        logic [31:0]          blkFadQ[$];
        logic [BlkWidth-1:0]  blkPixQ[$];
        logic [SadWidth-1:0]  expSadQ[$];
        logic [31:0]          expFadQ[$];

        bit                   stalls;
        int                   resultsSeen = 0;

        tbClock #(.PeriodNs(4.0)) clock0 (.Clk(Clk));

        sadTop #(
                .PixWidth  (PixWidth),
                .BlockSize (BlockSize)
        ) dut0 (
                .Clk      (Clk),
                .arstN    (arstN),
                .pixValid (pixValid),
                .pixData  (pixData),
                .op       (op),
                .fad      (fad),
                .resReady (resReady),
                .pixReady (pixReady),
                .resValid (resValid),
                .resSad   (resSad),
                .resFad   (resFad)
        );

        ////////////////////////////////////////////////////////////////////////////
        // Checks
        ////////////////////////////////////////////////////////////////////////////

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Result: FAILED");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic checkSad(input logic [SadWidth-1:0] got, input logic [SadWidth-1:0] exp);
                if (got !== exp) begin
                        abortRun($sformatf("Error: resSad is 0x%h, expected 0x%h", got, exp));
                end
        endtask

        task automatic checkFad(input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        abortRun($sformatf("Error: resFad is 0x%h, expected 0x%h", got, exp));
                end
        endtask

        task automatic checkFlag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        abortRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Input file
        ////////////////////////////////////////////////////////////////////////////

        task automatic readInput();
                int                   fd;
                int                   code;
                string                tag;
                string                rest;
                logic [31:0]          opVal;
                logic [31:0]          fadVal;
                logic [31:0]          pixVal;
                logic [31:0]          sadVal;
                logic [BlkWidth-1:0]  pixels;

                fd = $fopen("dv/sadInput.txt", "r");
                if (fd == 0) begin
                        abortRun("Could not open the input file dv/sadInput.txt");
                end
                while (!$feof(fd)) begin
                        code = $fscanf(fd, "%s", tag);
                        if (code != 1) begin
                                break;
                        end
                        if (tag == "#") begin
                                code = $fgets(rest, fd);
                        end else if (tag == "B") begin
                                code = $fscanf(fd, "%h %h", opVal, fadVal);
                                for (int i = 0; i < BlockSize; i++) begin
                                        code += $fscanf(fd, "%h", pixVal);
                                        pixels[i*PixWidth +: PixWidth] = pixVal[PixWidth-1:0];
                                end
                                if (code != BlockSize + 2) begin
                                        abortRun("A block line in the input file is incomplete");
                                end
                                blkOpQ.push_back(sadOpT'(opVal[1:0]));
                                blkFadQ.push_back(fadVal);
                                blkPixQ.push_back(pixels);
                        end else if (tag == "R") begin
                                code = $fscanf(fd, "%h %h", sadVal, fadVal);
                                if (code != 2) begin
                                        abortRun("A result line in the input file is incomplete");
                                end
                                expSadQ.push_back(sadVal[SadWidth-1:0]);
                                expFadQ.push_back(fadVal);
                        end else begin
                                abortRun({"The input file has a line with unknown tag ", tag});
                        end
                end
                $fclose(fd);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Pixel driver and result collector
        ////////////////////////////////////////////////////////////////////////////

        task automatic sendBlock(input int b);
                int  gap;
                int  waitCnt;
                bit  taken;

                for (int i = 0; i < BlockSize; i++) begin
                        gap = stalls ? int'($urandom_range(0, 2)) : 0;
                        repeat (gap) begin
                                pixValid <= 1'b0;
                                @(posedge Clk);
                        end
                        pixValid <= 1'b1;
                        pixData  <= blkPixQ[b][i*PixWidth +: PixWidth];
                        // Later beats carry junk, the packer must keep the first
                        op  <= (i == 0) ? blkOpQ[b] : SadNop;
                        fad <= (i == 0) ? blkFadQ[b] : {16'hdead, 16'(i)};
                        taken   = 1'b0;
                        waitCnt = 0;
                        while (!taken) begin
                                @(negedge Clk);
                                taken = pixReady;
                                @(posedge Clk);
                                waitCnt++;
                                if (!taken && waitCnt > WaitLimit) begin
                                        abortRun($sformatf("Timed out: pixel %0d of block %0d %s",
                                                 i, b, "was never accepted"));
                                end
                        end
                end
        endtask

        task automatic driveBlocks();
                for (int b = 0; b < blkOpQ.size(); b++) begin
                        sendBlock(b);
                end
                pixValid <= 1'b0;
        endtask

        task automatic collectResults();
                int                   waitCnt;
                bit                   got;
                logic [SadWidth-1:0]  sad;
                logic [31:0]          addr;

                for (int k = 0; k < expSadQ.size(); k++) begin
                        got     = 1'b0;
                        waitCnt = 0;
                        while (!got) begin
                                @(negedge Clk);
                                if (resValid && resReady) begin
                                        got  = 1'b1;
                                        sad  = resSad;
                                        addr = resFad;
                                end
                                @(posedge Clk);
                                resReady <= stalls ? ($urandom_range(0, 2) != 0) : 1'b1;
                                waitCnt++;
                                if (!got && waitCnt > WaitLimit) begin
                                        abortRun($sformatf("Timed out waiting for result %0d", k));
                                end
                        end
                        checkSad(sad, expSadQ[k]);
                        checkFad(addr, expFadQ[k]);
                end
                resReady <= 1'b1;
        endtask

        // Result handshakes as seen on the DUT outputs
        always @(negedge Clk) begin
                if (arstN && resValid && resReady) begin
                        resultsSeen++;
                end
        end

        // Nothing may come out once every expected result is in
        task automatic expectQuiet();
                repeat (QuietCycles) begin
                        @(negedge Clk);
                        if (resValid) begin
                                abortRun("A result appeared that the input file does not expect");
                        end
                end
                @(posedge Clk);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Main sequence
        ////////////////////////////////////////////////////////////////////////////

        initial begin
                arstN       = 1'b0;
                pixValid    = 1'b0;
                pixData     = '0;
                op          = SadNop;
                fad         = '0;
                resReady    = 1'b0;
                stalls      = 1'b0;
                void'($urandom(65));
                readInput();

                repeat (5) @(posedge Clk);
                arstN <= 1'b1;
                @(negedge Clk);
                checkFlag("resValid", resValid, 1'b0);
                checkFlag("pixReady", pixReady, 1'b1);
                @(posedge Clk);
                resReady <= 1'b1;

                // Clean pass first, then the same stream with gaps and stalls
                for (int pass = 0; pass < 2; pass++) begin
                        stalls = (pass == 1);
                        fork
                                driveBlocks();
                                collectResults();
                        join
                        expectQuiet();
                end

                if (resultsSeen == 2 * expSadQ.size()) begin
                        $display("Result: PASSED");
                        $finish;
                end else begin
                        $display("%0d results were handed over, %0d expected",
                                 resultsSeen, 2 * expSadQ.size());
                        $display("Result: FAILED");
                        $fatal(1, "Result count does not match the input file");
                end
        end

endmodule

//--- dv/sadTop_asserts.sv
`timescale 1ns/1ps

module sadTop_asserts #(
        parameter int PixWidth  = 8,
        parameter int BlockSize = 16
) (
        input logic                                   Clk,
        input logic                                   arstN,
        input logic                                   pixValid,
        input logic                                   pixReady,
        input logic                                   blkValid,
        input logic                                   resValid,
        input logic                                   resReady,
        input logic [PixWidth+$clog2(BlockSize)-1:0]  resSad,
        input logic [31:0]                            resFad
);

        localparam int CntWidth = $clog2(BlockSize);

        logic [CntWidth-1:0]  beatCnt;

        // Accepted pixels modulo the block size
        always_ff @(posedge Clk or negedge arstN) begin
                if (!arstN) begin
                        beatCnt <= '0;
                end else if (pixValid && pixReady) begin
                        beatCnt <= beatCnt + CntWidth'(1);
                end
        end

        // Result and its payload frozen until taken
        resultHeldA: assert property (@(posedge Clk) disable iff (!arstN)
                resValid && !resReady |=> resValid && $stable(resSad) && $stable(resFad))
                else $error("resValid, resSad or resFad changed while resReady was low");

        // Last pixel of a block closes the pixel port while the block waits
        packerHoldA: assert property (@(posedge Clk) disable iff (!arstN)
                pixValid && pixReady && beatCnt == CntWidth'(BlockSize - 1)
                |=> blkValid && !pixReady)
                else $error("pixReady was high after a full block was collected");

        resetQuietA: assert property (@(posedge Clk)
                !arstN |-> !resValid)
                else $error("resValid was high during reset");

endmodule

bind sadTop sadTop_asserts #(
        .PixWidth  (PixWidth),
        .BlockSize (BlockSize)
) asserts0 (
        .Clk      (Clk),
        .arstN    (arstN),
        .pixValid (pixValid),
        .pixReady (pixReady),
        .blkValid (blkValid),
        .resValid (resValid),
        .resReady (resReady),
        .resSad   (resSad),
        .resFad   (resFad)
);

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
        parameter real PeriodNs = 4.0
) (
        output logic Clk
);

        initial begin
                Clk = 1'b0;
                forever begin
                        #(PeriodNs / 2.0) Clk = ~Clk;
                end
        end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the SAD slice with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
        --top-module sadTb -f compile.f -o simSad \
        > build.log 2>&1 \
        || { cat build.log; echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simSad > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log \
        && { echo "Simulation reported a failure, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log \
        || { echo "Simulation ended without a pass line, see sim.log"; exit 1; }

echo "Simulation passed"
exit 0
